//--- Bender.yml
package:
  name: conv_engine

sources:
  - logic/conv_pkg.sv
  - logic/conv_linebuffer.sv
  - logic/conv_sop.sv
  - logic/conv_psum_fifo.sv
  - logic/conv_shift_adder.sv
  - logic/conv_engine_top.sv
  - target: simulation
    files:
      - sim/tb_conv_engine.sv

//--- files.f
logic/conv_pkg.sv
logic/conv_linebuffer.sv
logic/conv_sop.sv
logic/conv_psum_fifo.sv
logic/conv_shift_adder.sv
logic/conv_engine_top.sv
sim/tb_conv_engine.sv

//--- logic/conv_engine_top.sv
/*
 * streaming 3x3 convolution engine, one input map, one output channel
 * cfg_i and weights_i must stay stable while an image is in flight
 * y_in is only read when cfg_i.use_bias is 0
 */
`timescale 1ns/10ps
`default_nettype none

module conv_engine_top #(
   parameter int LINE_MAX = 32,
   parameter int QF       = 8
) (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire conv_pkg::conv_cfg_t cfg_i,
   input  wire conv_pkg::weights_t  weights_i,
   input  wire                      x_valid_i,
   input  wire conv_pkg::pix_beat_t x_data_i,
   output logic                     x_ready_o,
   input  wire                      y_in_valid_i,
   input  wire conv_pkg::pix_beat_t y_in_data_i,
   output logic                     y_in_ready_o,
   output logic                     y_out_valid_o,
   output conv_pkg::pix_beat_t      y_out_data_o,
   input  wire                      y_out_ready_i
);

   // window stream
   logic                win_valid;
   logic                win_ready;
   conv_pkg::win_beat_t win;
   // sum-of-products stream
   logic                sum_valid;
   logic                sum_ready;
   conv_pkg::acc_beat_t sum;
   // buffered partial sums
   logic                psum_valid;
   logic                psum_ready;
   conv_pkg::pix_beat_t psum;

   conv_linebuffer #(
      .LINE_MAX (LINE_MAX)
   ) i_conv_linebuffer (
      .clk          (clk),
      .rst_n        (rst_n),
      .line_width_i (cfg_i.line_width),
      .pix_valid_i  (x_valid_i),
      .pix_i        (x_data_i),
      .pix_ready_o  (x_ready_o),
      .win_valid_o  (win_valid),
      .win_o        (win),
      .win_ready_i  (win_ready)
   );

   conv_sop i_conv_sop (
      .clk         (clk),
      .rst_n       (rst_n),
      .weights_i   (weights_i),
      .win_valid_i (win_valid),
      .win_i       (win),
      .win_ready_o (win_ready),
      .sum_valid_o (sum_valid),
      .sum_o       (sum),
      .sum_ready_i (sum_ready)
   );

   conv_psum_fifo i_conv_psum_fifo (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_valid_i  (y_in_valid_i),
      .in_i        (y_in_data_i),
      .in_ready_o  (y_in_ready_o),
      .out_valid_o (psum_valid),
      .out_o       (psum),
      .out_ready_i (psum_ready)
   );

   conv_shift_adder #(
      .QF (QF)
   ) i_conv_shift_adder (
      .clk          (clk),
      .rst_n        (rst_n),
      .cfg_i        (cfg_i),
      .sum_valid_i  (sum_valid),
      .sum_i        (sum),
      .sum_ready_o  (sum_ready),
      .psum_valid_i (psum_valid),
      .psum_i       (psum),
      .psum_ready_o (psum_ready),
      .res_valid_o  (y_out_valid_o),
      .res_o        (y_out_data_o),
      .res_ready_i  (y_out_ready_i)
   );

endmodule

`default_nettype wire

//--- logic/conv_linebuffer.sv
/*
 * line buffer forming 3x3 windows, no zero padding
 * line_width_i must be 3 .. LINE_MAX and stable during an image
 * only fully covered windows are emitted, counters restart after last
 */
`timescale 1ns/10ps
`default_nettype none

module conv_linebuffer #(
   parameter int LINE_MAX = 32
) (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire [conv_pkg::LINE_AW-1:0]    line_width_i,
   input  wire                            pix_valid_i,
   input  wire conv_pkg::pix_beat_t       pix_i,
   output logic                           pix_ready_o,
   output logic                           win_valid_o,
   output conv_pkg::win_beat_t            win_o,
   input  wire                            win_ready_i
);

   localparam int MEM_AW = (LINE_MAX > 1) ? $clog2(LINE_MAX) : 1;

   conv_pkg::pix_t mem_near [LINE_MAX];  // previous line
   conv_pkg::pix_t mem_far  [LINE_MAX];  // line before that

   conv_pkg::window_t            win_q;
   conv_pkg::window_t            win_d;
   conv_pkg::pix_t               up_near;
   conv_pkg::pix_t               up_far;
   logic [conv_pkg::LINE_AW-1:0] col_q;
   logic [1:0]                   row_q;  // saturates at 2
   logic [MEM_AW-1:0]            addr;
   logic                         accept;
   logic                         win_ok;

   // take a pixel while the output register is empty or draining
   assign pix_ready_o = !win_valid_o || win_ready_i;
   assign accept      = pix_valid_i && pix_ready_o;

   assign addr    = col_q[MEM_AW-1:0];
   assign up_near = mem_near[addr];
   assign up_far  = mem_far[addr];
   assign win_ok  = (col_q >= 2) && (row_q == 2'd2);

   // shift window one column left, new column from memories and pixel
   always_comb begin
      for (int r = 0; r < 3; r++) begin
         win_d[r*3]     = win_q[r*3 + 1];
         win_d[r*3 + 1] = win_q[r*3 + 2];
      end
      win_d[2] = up_far;
      win_d[5] = up_near;
      win_d[8] = pix_i.data;
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         mem_far[addr]  <= up_near;     // rotate lines at this column
         mem_near[addr] <= pix_i.data;
         win_q          <= win_d;
      end
   end

   // column modulo line width, row count
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         col_q <= '0;
         row_q <= '0;
      end else if (accept) begin
         if (pix_i.last) begin
            col_q <= '0;
            row_q <= '0;
         end else if (col_q == line_width_i - 1'b1) begin
            col_q <= '0;
            if (row_q != 2'd2) begin
               row_q <= row_q + 1'b1;
            end
         end else begin
            col_q <= col_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         win_valid_o <= 1'b0;
      end else if (pix_ready_o) begin
         win_valid_o <= accept && win_ok;
      end
   end

   always_ff @(posedge clk) begin
      if (accept && win_ok) begin
         win_o.win  <= win_d;
         win_o.last <= pix_i.last;  // last pixel always closes a full window
      end
   end

endmodule

`default_nettype wire

//--- logic/conv_pkg.sv
/*
 * shared widths and stream types for the 3x3 convolution engine
 * pixels, weights, bias and partial sums are signed 16-bit fixed point
 * window and weight taps are row-major, tap 0 is the top-left pixel
 */
`default_nettype none

package conv_pkg;

   localparam int PIX_W   = 16;           // pixel and weight width
   localparam int TAPS    = 9;            // fixed 3x3 filter
   localparam int ACC_W   = 2*PIX_W + 4;  // nine products need four growth bits
   localparam int LINE_AW = 8;            // line-length field

   typedef logic signed [PIX_W-1:0] pix_t;
   typedef pix_t [TAPS-1:0] window_t;
   typedef pix_t [TAPS-1:0] weights_t;
   typedef logic signed [ACC_W-1:0] acc_t;

   // one pixel or partial sum per beat
   typedef struct packed {
      pix_t data;
      logic last;
   } pix_beat_t;

   typedef struct packed {
      window_t win;
      logic    last;
   } win_beat_t;

   typedef struct packed {
      acc_t data;
      logic last;
   } acc_beat_t;

   // must stay stable while an image is in flight
   typedef struct packed {
      logic [LINE_AW-1:0] line_width;  // 3 .. LINE_MAX
      logic               use_bias;    // 0 takes the partial-sum stream
      logic               relu;
      pix_t               bias;
   } conv_cfg_t;

endpackage

`default_nettype wire

//--- logic/conv_psum_fifo.sv
/*
 * four-entry FIFO for the incoming partial-sum stream
 * a write is readable on the next cycle, ready is low while full
 */
`timescale 1ns/10ps
`default_nettype none

module conv_psum_fifo (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      in_valid_i,
   input  wire conv_pkg::pix_beat_t in_i,
   output logic                     in_ready_o,
   output logic                     out_valid_o,
   output conv_pkg::pix_beat_t      out_o,
   input  wire                      out_ready_i
);

   localparam int DEPTH = 4;
   localparam int PTR_W = $clog2(DEPTH);

   conv_pkg::pix_beat_t mem [DEPTH];
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   logic [PTR_W:0]      count;
   logic                push;
   logic                pop;

   assign in_ready_o  = (count != DEPTH[PTR_W:0]);
   assign out_valid_o = (count != '0);
   assign out_o       = mem[rd_ptr];

   assign push = in_valid_i && in_ready_o;
   assign pop  = out_valid_o && out_ready_i;

   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= in_i;
   end

   // pointers wrap naturally at four entries
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/conv_shift_adder.sv
/*
 * adds bias or partial sum to the window sum, shifts right by QF
 * (truncating), saturates to 16 bits and optionally rectifies
 * in partial-sum mode every result pops exactly one partial sum
 */
`timescale 1ns/10ps
`default_nettype none

module conv_shift_adder #(
   parameter int QF = 8
) (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire conv_pkg::conv_cfg_t cfg_i,
   input  wire                      sum_valid_i,
   input  wire conv_pkg::acc_beat_t sum_i,
   output logic                     sum_ready_o,
   input  wire                      psum_valid_i,
   input  wire conv_pkg::pix_beat_t psum_i,
   output logic                     psum_ready_o,
   output logic                     res_valid_o,
   output conv_pkg::pix_beat_t      res_o,
   input  wire                      res_ready_i
);

   localparam int SUM_W = conv_pkg::ACC_W + 1;  // one guard bit for the add
   localparam logic signed [SUM_W-1:0] SAT_MAX = 2**(conv_pkg::PIX_W-1) - 1;
   localparam logic signed [SUM_W-1:0] SAT_MIN = -(2**(conv_pkg::PIX_W-1));

   logic                    res_free;
   logic                    take;
   logic signed [SUM_W-1:0] addend;
   logic signed [SUM_W-1:0] total;
   logic signed [SUM_W-1:0] shifted;
   conv_pkg::pix_t          sat;
   conv_pkg::pix_t          act;

   // sum and partial sum move together through the join
   assign res_free     = !res_valid_o || res_ready_i;
   assign sum_ready_o  = res_free && (cfg_i.use_bias || psum_valid_i);
   assign psum_ready_o = res_free && !cfg_i.use_bias && sum_valid_i;
   assign take         = sum_valid_i && sum_ready_o;

   always_comb begin
      addend  = cfg_i.use_bias ? SUM_W'(cfg_i.bias) : SUM_W'(psum_i.data);
      total   = SUM_W'(sum_i.data) + addend;
      shifted = total >>> QF;
      if (shifted > SAT_MAX) begin
         sat = SAT_MAX[conv_pkg::PIX_W-1:0];
      end else if (shifted < SAT_MIN) begin
         sat = SAT_MIN[conv_pkg::PIX_W-1:0];
      end else begin
         sat = shifted[conv_pkg::PIX_W-1:0];
      end
      act = (cfg_i.relu && sat[conv_pkg::PIX_W-1]) ? '0 : sat;  // rectifier
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         res_valid_o <= 1'b0;
      end else if (res_free) begin
         res_valid_o <= take;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         res_o.data <= act;
         res_o.last <= sum_i.last;
      end
   end

endmodule

`default_nettype wire

//--- logic/conv_sop.sv
/*
 * two-stage signed sum of products over a 3x3 window
 * stage 1 registers nine products, stage 2 the adder tree
 * a stall on the output holds both stages, nothing is dropped
 */
`timescale 1ns/10ps
`default_nettype none

module conv_sop (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire conv_pkg::weights_t  weights_i,
   input  wire                      win_valid_i,
   input  wire conv_pkg::win_beat_t win_i,
   output logic                     win_ready_o,
   output logic                     sum_valid_o,
   output conv_pkg::acc_beat_t      sum_o,
   input  wire                      sum_ready_i
);

   localparam int PROD_W = 2*conv_pkg::PIX_W;

   logic signed [PROD_W-1:0] prod_q [conv_pkg::TAPS];
   logic                     prod_valid_q;
   logic                     prod_last_q;
   conv_pkg::acc_t           tree_sum;
   logic                     adv_prod;
   logic                     adv_sum;

   // each stage moves when the next one is empty or handing off
   assign adv_sum     = !sum_valid_o || sum_ready_i;
   assign adv_prod    = !prod_valid_q || adv_sum;
   assign win_ready_o = adv_prod;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         prod_valid_q <= 1'b0;
         sum_valid_o  <= 1'b0;
      end else begin
         if (adv_prod) prod_valid_q <= win_valid_i;
         if (adv_sum)  sum_valid_o  <= prod_valid_q;
      end
   end

   always_ff @(posedge clk) begin
      if (adv_prod && win_valid_i) begin
         for (int i = 0; i < conv_pkg::TAPS; i++) begin
            prod_q[i] <= $signed(win_i.win[i]) * $signed(weights_i[i]);
         end
         prod_last_q <= win_i.last;
      end
   end

   // full precision, sign-extended into the accumulator
   always_comb begin
      tree_sum = '0;
      for (int i = 0; i < conv_pkg::TAPS; i++) begin
         tree_sum = tree_sum + conv_pkg::acc_t'(prod_q[i]);
      end
   end

   always_ff @(posedge clk) begin
      if (adv_sum && prod_valid_q) begin
         sum_o.data <= tree_sum;
         sum_o.last <= prod_last_q;
      end
   end

endmodule

`default_nettype wire

//--- sim/conv_vectors.txt
// hex words; first word is the record count, then per record:
// cfg (line_width[25:18] use_bias[17] relu[16] bias[15:0]), weights tap 0..8,
// pixel count, pixels row-major, partial sums (use_bias 0 only), expected results
6
// bias mode, identity centre weight, 5x5
160000
0000 0000 0000 0000 0001 0000 0000 0000 0000
19
0011 FEEF 0211 FCEF 0411
FAEF 0611 F8EF 0811 F6EF
0A11 F4EF 0C11 F2EF 0E11
F0EF 1011 EEEF 1211 ECEF
1411 EAEF 1611 E8EF 1811
0006 FFF8 0008 FFF4 000C FFF2 0010 FFEE 0012
// bias mode, mixed signs, large bias, saturation both ways
E4000
0100 FF00 0200 FE00 0400 FC00 0080 FF80 0001
F
7FFF 8000 7FFF
0000 7FFF 0000
7FFF 8000 7FFF
0000 0000 7FFF
0100 0010 0003
7FFF 8000 00B9
// bias mode with rectifier, edge filter
130080
0001 0000 FFFF 0002 0000 FFFE 0001 0000 FFFF
10
1000 0000 0000 3000
1000 0000 0000 3000
1000 0000 0000 3000
2000 0000 0000 1000
0040 0000 0050 0000
// partial-sum mode, bias field must be ignored
107FFF
0001 0002 0003 0004 0005 0006 0007 0008 0009
10
0000 0100 0200 0300
0400 0500 0600 0700
0800 0900 0A00 0B00
0C00 0D00 0E00 0F00
0100 FF00 0080 FF7F
0130 015B 01E3 020F
// two images back to back, line width 6 then 3
181234
0001 0001 0001 0001 0001 0001 0001 0001 0001
12
0000 0100 0200 0300 0400 0500
0600 0700 0800 0900 0A00 0B00
0C00 0D00 0E00 0F00 1000 1100
0000 0200 FE00 0001
003F 004A 004F 005A
E0180
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
C
0000 0100 0200
0300 0400 0500
0600 0700 0800
0900 0A00 0B00
FFDD FFC2

//--- sim/tb_conv_engine.sv
/*
 * self-checking testbench for conv_engine_top with QF = 8
 * records come from sim/conv_vectors.txt, run from the project root
 * images run one after another, cfg and weights change only between them
 */
`timescale 1ns/10ps
`default_nettype none

module tb_conv_engine;

   localparam int LINE_MAX  = 32;
   localparam int QF        = 8;
   localparam int VEC_DEPTH = 512;
   localparam int TIMEOUT   = 2000;  // cycles allowed per wait loop
   localparam logic [31:0] SEED = 32'h2684_0dda;

   logic                clk;
   logic                rst_n;
   conv_pkg::conv_cfg_t cfg;
   conv_pkg::weights_t  weights;
   logic                x_valid;
   conv_pkg::pix_beat_t x_data;
   logic                x_ready;
   logic                y_in_valid;
   conv_pkg::pix_beat_t y_in_data;
   logic                y_in_ready;
   logic                y_out_valid;
   conv_pkg::pix_beat_t y_out_data;
   logic                y_out_ready;

   logic [31:0] vec_mem [VEC_DEPTH];
   logic [31:0] x_rng;
   logic [31:0] y_in_rng;
   logic [31:0] y_out_rng;
   int          errors;
   int          image;

   conv_engine_top #(
      .LINE_MAX (LINE_MAX),
      .QF       (QF)
   ) i_conv_engine_top (
      .clk           (clk),
      .rst_n         (rst_n),
      .cfg_i         (cfg),
      .weights_i     (weights),
      .x_valid_i     (x_valid),
      .x_data_i      (x_data),
      .x_ready_o     (x_ready),
      .y_in_valid_i  (y_in_valid),
      .y_in_data_i   (y_in_data),
      .y_in_ready_o  (y_in_ready),
      .y_out_valid_o (y_out_valid),
      .y_out_data_o  (y_out_data),
      .y_out_ready_i (y_out_ready)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic report_error(input string msg);
      errors++;
      stop_run($sformatf("ERR %0t: %s", $realtime, msg));
   endtask

   task automatic check_pix(input conv_pkg::pix_t got, input conv_pkg::pix_t exp, input int idx);
      if (got !== exp) begin
         report_error($sformatf("image %0d result %0d is %h, expected %h",
                                image, idx, got, exp));
      end
   endtask

   task automatic check_last(input logic got, input logic exp, input int idx);
      if (got !== exp) begin
         report_error($sformatf("image %0d result %0d last flag is %b, expected %b",
                                image, idx, got, exp));
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string name);
      if (got !== exp) begin
         report_error($sformatf("%s is %b, expected %b", name, got, exp));
      end
   endtask

   // called at posedge + 1, returns at posedge + 1
   task automatic drive_pixels(input int base, input int n);
      int wait_cnt;
      for (int i = 0; i < n; i++) begin
         x_rng = lcg_next(x_rng);
         while (x_rng[31:30] == 2'b00) begin  // random gap
            x_valid = 1'b0;
            @(posedge clk);
            #1;
            x_rng = lcg_next(x_rng);
         end
         x_valid     = 1'b1;
         x_data.data = conv_pkg::pix_t'(vec_mem[base + i][15:0]);
         x_data.last = (i == n - 1);
         wait_cnt    = 0;
         @(negedge clk);
         while (!x_ready) begin
            wait_cnt++;
            if (wait_cnt > TIMEOUT) stop_run("timeout: pixel input was never ready");
            @(negedge clk);
         end
         @(posedge clk);  // beat transfers here
         #1;
      end
      x_valid = 1'b0;
   endtask

   task automatic drive_psums(input int base, input int n);
      int wait_cnt;
      for (int i = 0; i < n; i++) begin
         y_in_rng = lcg_next(y_in_rng);
         while (y_in_rng[31:30] == 2'b00) begin
            y_in_valid = 1'b0;
            @(posedge clk);
            #1;
            y_in_rng = lcg_next(y_in_rng);
         end
         y_in_valid     = 1'b1;
         y_in_data.data = conv_pkg::pix_t'(vec_mem[base + i][15:0]);
         y_in_data.last = (i == n - 1);
         wait_cnt       = 0;
         @(negedge clk);
         while (!y_in_ready) begin
            wait_cnt++;
            if (wait_cnt > TIMEOUT) stop_run("timeout: partial-sum input was never ready");
            @(negedge clk);
         end
         @(posedge clk);
         #1;
      end
      y_in_valid = 1'b0;
   endtask

   task automatic collect_results(input int base, input int m);
      int got;
      int idle;
      got  = 0;
      idle = 0;
      while (got < m) begin
         y_out_rng   = lcg_next(y_out_rng);
         y_out_ready = (y_out_rng[31:30] != 2'b00);  // random back-pressure
         @(negedge clk);
         if (y_out_valid && y_out_ready) begin
            check_pix(y_out_data.data, conv_pkg::pix_t'(vec_mem[base + got][15:0]), got);
            check_last(y_out_data.last, (got == m - 1), got);
            got++;
            idle = 0;
         end else begin
            idle++;
            if (idle > TIMEOUT) stop_run("timeout: the engine stopped producing results");
         end
         @(posedge clk);
         #1;
      end
      y_out_ready = 1'b0;
   endtask

   // nothing may follow the final result of an image
   task automatic check_no_extra();
      y_out_ready = 1'b1;
      repeat (16) begin
         @(negedge clk);
         check_flag(y_out_valid, 1'b0, "y_out valid after the final result");
      end
      @(posedge clk);
      #1;
      y_out_ready = 1'b0;
   endtask

   initial begin
      int ptr;
      int n_rec;
      int n_pix;
      int n_out;
      int lw;
      int pix_base;
      int psum_base;
      int exp_base;
      rst_n       = 1'b0;
      cfg         = '0;
      weights     = '0;
      x_valid     = 1'b0;
      x_data      = '0;
      y_in_valid  = 1'b0;
      y_in_data   = '0;
      y_out_ready = 1'b0;
      errors      = 0;
      image       = 0;
      x_rng       = SEED;
      y_in_rng    = SEED ^ 32'h5a5a_5a5a;
      y_out_rng   = SEED ^ 32'hc3c3_3c3c;
      $readmemh("sim/conv_vectors.txt", vec_mem);
      if ($isunknown(vec_mem[0])) stop_run("could not read the vector file sim/conv_vectors.txt");
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      check_flag(y_out_valid, 1'b0, "y_out valid after reset");
      check_flag(x_ready, 1'b1, "x ready after reset");
      check_flag(y_in_ready, 1'b1, "y_in ready after reset");
      @(posedge clk);
      #1;
      n_rec = int'(vec_mem[0]);
      ptr   = 1;
      for (image = 1; image <= n_rec; image++) begin
         cfg = conv_pkg::conv_cfg_t'(vec_mem[ptr][$bits(conv_pkg::conv_cfg_t)-1:0]);
         for (int t = 0; t < conv_pkg::TAPS; t++) begin
            weights[t] = conv_pkg::pix_t'(vec_mem[ptr + 1 + t][15:0]);
         end
         n_pix = int'(vec_mem[ptr + 10]);
         lw    = int'(cfg.line_width);
         if (lw < 3 || lw > LINE_MAX || n_pix % lw != 0 || n_pix / lw < 3) begin
            stop_run($sformatf("record %0d of the vector file is malformed", image));
         end
         n_out     = (lw - 2) * (n_pix / lw - 2);  // fully covered windows only
         pix_base  = ptr + 11;
         psum_base = pix_base + n_pix;
         exp_base  = cfg.use_bias ? psum_base : psum_base + n_out;
         ptr       = exp_base + n_out;
         fork
            drive_pixels(pix_base, n_pix);
            if (!cfg.use_bias) drive_psums(psum_base, n_out);
            collect_results(exp_base, n_out);
         join
         check_no_extra();
      end
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire
